//--- filelist.f
source/osc_stream_pkg.sv
source/osc_bus_pkg.sv
source/osc_regs.sv
source/osc_dec_avg.sv
source/osc_edge.sv
source/osc_acq.sv
source/osc_top.sv
testbench/osc_tb_clk.sv
testbench/osc_acq_assert.sv
testbench/osc_tb.sv

//--- Bender.yml
package:
  name: osc_channel

sources:
  - source/osc_stream_pkg.sv
  - source/osc_bus_pkg.sv
  - source/osc_regs.sv
  - source/osc_dec_avg.sv
  - source/osc_edge.sv
  - source/osc_acq.sv
  - source/osc_top.sv
  - target: test
    files:
      - testbench/osc_tb_clk.sv
      - testbench/osc_acq_assert.sv
      - testbench/osc_tb.sv

//--- testbench/osc_tb.sv
////////////////////////////////////////
// table driven testbench for osc_top
// bus tasks, sample model, checks
////////////////////////////////////////

`default_nettype none

module osc_tb
  import osc_stream_pkg::*;
  import osc_bus_pkg::*;
;

  // one test case of the table
  typedef struct {
    int          dec;
    int          shr;
    bit          avg;
    int          pre;
    int          pst;
    int          pos;
    int          neg;
    bit          edg;
    logic [5:0]  mstr;
    logic [5:0]  mstp;
    logic [5:0]  mtrg;
    int          kind;
    int          n_a;
    int          evt;
    int          n_b;
    bit          bp;
    bit          exp_last;
  } tc_t;

  typedef struct {
    int          addr;
    logic [31:0] wdata;
    logic [31:0] rexp;
  } rw_t;

  logic       bus;
  logic       rst_n;
  bus_req_t   bus_req;
  bus_rsp_t   bus_rsp;
  logic [1:0] ext_evn;
  stream_t    adc_in;
  logic       adc_ready;
  stream_t    scope_out;
  logic       scope_ready;
  logic       evn_lst;

  logic [31:0] lfsr;
  bit          bp_on;
  int          smp[$];
  int          out_data[$];
  bit          out_last[$];
  int          lst_cnt;

  // golden model results
  int exp_data[$];
  bit exp_last[$];
  int n_exp_a;
  int m_pre;
  int m_pst;
  bit m_run;
  bit m_stp;
  bit m_trg;

  tc_t cases[5];
  rw_t rw_tab[10];

  osc_tb_clk u_clk (
    .bus   (bus),
    .rst_n (rst_n)
  );

  osc_top u_osc_top (
    .bus         (bus),
    .rst_n       (rst_n),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .ext_evn     (ext_evn),
    .adc_in      (adc_in),
    .adc_ready   (adc_ready),
    .scope_out   (scope_out),
    .scope_ready (scope_ready),
    .evn_lst     (evn_lst)
  );

  ////////////////////////////////////////
  // random numbers and reporting
  ////////////////////////////////////////

  // galois lfsr with taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input longint got, input longint exp);
    assert (got == exp) else begin
      $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // bound checker on the acquisition controller
  always @(posedge bus) begin
    if (u_osc_top.u_acq.u_acq_assert.n_fail != 0) begin
      $display("concurrent assertion failed on the acquisition stream at %0t", $time);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // bus access with ack one cycle later
  ////////////////////////////////////////

  task automatic bus_access(input bit wr, input int addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    @(posedge bus);
    bus_req <= '{wen: wr, ren: !wr, addr: addr[addr_width-1:0], wdata: wdata};
    @(posedge bus);
    bus_req <= '0;
    // no ack in the request cycle
    check_value("bus_rsp.ack", bus_rsp.ack, 0);
    @(posedge bus);
    check_value("bus_rsp.ack", bus_rsp.ack, 1);
    rdata = bus_rsp.rdata;
  endtask

  task automatic bus_write(input int addr, input logic [31:0] wdata);
    logic [31:0] dummy;
    bus_access(1'b1, addr, wdata, dummy);
  endtask

  task automatic read_check(input int addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, addr, '0, rd);
    check_value($sformatf("bus_rsp.rdata @%0h", addr), rd, exp);
  endtask

  ////////////////////////////////////////
  // stream driver and monitor
  ////////////////////////////////////////

  // present samples lo..hi-1 and hold each until accepted
  task automatic feed(input int lo, input int hi);
    int t;
    @(posedge bus);
    for (int i = lo; i < hi; i++) begin
      adc_in <= '{valid: 1'b1, last: 1'b0, data: smp[i][15:0]};
      t = 0;
      do begin
        @(posedge bus);
        t++;
        if (t > 1000) report_timeout("adc_ready");
      end while (!adc_ready);
    end
    adc_in <= '0;
  endtask

  task automatic wait_count(input int n);
    int t;
    t = 0;
    while (out_data.size() < n) begin
      @(posedge bus);
      t++;
      if (t > 4000) report_timeout("output beats");
    end
  endtask

  // random back-pressure when enabled
  always @(posedge bus) begin
    scope_ready <= bp_on ? 1'(rand_bits(1)) : 1'b1;
  end

  always @(posedge bus) begin
    if (rst_n && scope_out.valid && scope_ready) begin
      out_data.push_back(int'(scope_out.data));
      out_last.push_back(scope_out.last);
    end
    if (rst_n && evn_lst) lst_cnt++;
  end

  ////////////////////////////////////////
  // golden model
  ////////////////////////////////////////

  task automatic build_model(input tc_t tc);
    int          dq[$];
    longint      acc;
    int          cnt;
    int          nb;
    int          s;
    bit          armed;
    bit          fire;
    bit          arm_hit;
    logic [15:0] t;
    exp_data.delete();
    exp_last.delete();
    acc = 0;
    cnt = 0;
    // decimate in groups of dec+1 samples
    foreach (smp[i]) begin
      acc += smp[i];
      if (cnt == tc.dec) begin
        t = 16'(acc >>> tc.shr);
        dq.push_back(tc.avg ? int'($signed(t)) : smp[i]);
        acc = 0;
        cnt = 0;
      end else begin
        cnt++;
      end
    end
    nb = tc.n_a / (tc.dec + 1);
    armed = 0;
    m_run = 1;
    m_trg = 0;
    m_stp = 0;
    m_pre = 0;
    m_pst = 0;
    n_exp_a = 0;
    for (int i = 0; i <= dq.size(); i++) begin
      // event between the two parts
      if (i == nb) begin
        n_exp_a = exp_data.size();
        if (tc.evt == 1 && tc.mtrg[evn_sw_trg] && m_run && !m_trg && m_pre >= tc.pre)
          m_trg = 1;
        if (tc.evt == 2 && tc.mstp[evn_ext0] && m_run) begin
          m_run = 0;
          m_stp = 1;
        end
      end
      if (i == dq.size()) break;
      s = dq[i];
      // hysteresis detector sees every beat
      fire = armed && (tc.edg ? (s <= tc.neg) : (s >= tc.pos));
      arm_hit = tc.edg ? (s > tc.pos) : (s <= tc.neg);
      if (fire) armed = 0;
      else if (arm_hit) armed = 1;
      if (m_run) begin
        exp_data.push_back(s);
        if (!m_trg) begin
          // the trigger beat is still a pre beat
          exp_last.push_back(0);
          if (fire && tc.mtrg[evn_lvl] && m_pre >= tc.pre) m_trg = 1;
          m_pre++;
        end else begin
          m_pst++;
          exp_last.push_back(m_pst >= tc.pst);
          if (m_pst >= tc.pst) m_run = 0;
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // one table entry
  ////////////////////////////////////////

  task automatic run_case(input int idx, input tc_t tc);
    int n_lst;
    n_lst = 0;
    bus_write(reg_ctl, 32'h1);
    bus_write(reg_dec, tc.dec);
    bus_write(reg_shr, tc.shr);
    bus_write(reg_avg, tc.avg);
    bus_write(reg_pre, tc.pre);
    bus_write(reg_pst, tc.pst);
    bus_write(reg_pos, tc.pos);
    bus_write(reg_neg, tc.neg);
    bus_write(reg_edg, tc.edg);
    bus_write(reg_msk_str, tc.mstr);
    bus_write(reg_msk_stp, tc.mstp);
    bus_write(reg_msk_trg, tc.mtrg);
    // ramp or random samples
    smp.delete();
    for (int i = 0; i < tc.n_a + tc.n_b; i++) begin
      if (tc.kind == 1) smp.push_back(-100 + 10 * i);
      else smp.push_back(int'($signed(16'(rand_bits(16)))));
    end
    build_model(tc);
    out_data.delete();
    out_last.delete();
    lst_cnt = 0;
    bus_write(reg_ctl, 32'h2);
    bp_on <= tc.bp;
    feed(0, tc.n_a);
    wait_count(n_exp_a);
    if (tc.evt == 1) begin
      bus_write(reg_ctl, 32'h8);
    end else if (tc.evt == 2) begin
      @(posedge bus);
      ext_evn <= 2'b01;
      @(posedge bus);
      ext_evn <= 2'b00;
    end
    feed(tc.n_a, tc.n_a + tc.n_b);
    wait_count(exp_data.size());
    // let stray beats show up
    repeat (20) @(posedge bus);
    bp_on <= 0;
    check_value($sformatf("case %0d beat count", idx), out_data.size(), exp_data.size());
    foreach (exp_data[i]) begin
      check_value($sformatf("scope_out.data[%0d]", i), out_data[i], exp_data[i]);
      check_value($sformatf("scope_out.last[%0d]", i), out_last[i], exp_last[i]);
      n_lst += exp_last[i];
    end
    check_value("evn_lst count", lst_cnt, n_lst);
    check_value($sformatf("case %0d record end", idx), lst_cnt, tc.exp_last);
    read_check(reg_sts_pre, m_pre);
    read_check(reg_sts_pst, m_pst);
    read_check(reg_ctl, {28'h0, m_trg, m_stp, m_run, 1'b0});
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int t;
    bus_req     = '0;
    ext_evn     = 2'b00;
    adc_in      = '0;
    scope_ready = 1'b1;
    bp_on       = 0;
    lst_cnt     = 0;
    lfsr        = 32'h81d6caf5;

    // dec, shr, avg, pre, pst, pos, neg, edg, masks, kind, n_a, evt, n_b, bp, last
    cases[0] = '{3, 0, 0, 0, 1000, 0, 0, 0, 6'h01, 6'h00, 6'h00, 0, 32, 0, 0, 0, 0};
    cases[1] = '{3, 2, 1, 0, 1000, 0, 0, 0, 6'h01, 6'h00, 6'h00, 0, 32, 0, 0, 0, 0};
    cases[2] = '{0, 0, 0, 4, 8, 0, 0, 0, 6'h01, 6'h00, 6'h04, 0, 6, 1, 12, 0, 1};
    cases[3] = '{0, 0, 0, 2, 5, 50, -50, 0, 6'h01, 6'h00, 6'h08, 1, 30, 0, 0, 0, 1};
    cases[4] = '{1, 1, 1, 0, 1000, 0, 0, 0, 6'h01, 6'h10, 6'h00, 0, 40, 2, 10, 1, 0};

    // write value and sign or zero extended read back
    rw_tab[0] = '{reg_pos, 32'h0000_8123, 32'hffff_8123};
    rw_tab[1] = '{reg_neg, 32'h0000_1234, 32'h0000_1234};
    rw_tab[2] = '{reg_dec, 32'hffff_ffff, 32'h0001_ffff};
    rw_tab[3] = '{reg_shr, 32'h0000_00ff, 32'h0000_000f};
    rw_tab[4] = '{reg_avg, 32'h0000_0003, 32'h0000_0001};
    rw_tab[5] = '{reg_msk_trg, 32'h0000_00ff, 32'h0000_003f};
    rw_tab[6] = '{reg_pre, 32'hffff_ffff, 32'h7fff_ffff};
    rw_tab[7] = '{reg_pst, 32'h1234_5678, 32'h1234_5678};
    rw_tab[8] = '{reg_edg, 32'h0000_00fe, 32'h0000_0000};
    rw_tab[9] = '{'h2c, 32'hdead_beef, 32'h0000_0000};

    t = 0;
    while (!rst_n) begin
      @(posedge bus);
      t++;
      if (t > 100) report_timeout("reset release");
    end

    // reset values
    for (int a = 0; a <= 'h38; a += 4) begin
      read_check(a, 32'h0);
    end
    foreach (rw_tab[i]) begin
      bus_write(rw_tab[i].addr, rw_tab[i].wdata);
      read_check(rw_tab[i].addr, rw_tab[i].rexp);
    end

    foreach (cases[i]) begin
      run_case(i, cases[i]);
    end

    if (u_osc_top.u_acq.u_acq_assert.n_fail != 0) begin
      $display("concurrent assertion failed on the acquisition stream");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule : osc_tb

`default_nettype wire

//--- testbench/osc_acq_assert.sv
////////////////////////////////////////
// concurrent checks on the acquisition
// controller output stream
////////////////////////////////////////

`default_nettype none

module osc_acq_assert
  import osc_stream_pkg::*;
(
  input logic    bus,
  input logic    rst_n,
  input stream_t sto,
  input logic    sto_ready,
  input logic    evn_lst
);

  // failed property count
  int n_fail = 0;

  // held beat must not change
  a_hold : assert property (@(posedge bus) disable iff (!rst_n)
    sto.valid && !sto_ready |=> sto.valid && $stable(sto.data))
    else begin
      $error("output beat changed while stalled");
      n_fail++;
    end

  // end event only with a transferred last beat
  a_lst : assert property (@(posedge bus) disable iff (!rst_n)
    evn_lst |-> sto.valid && sto.last && sto_ready)
    else begin
      $error("evn_lst without a last transfer");
      n_fail++;
    end

  a_rst : assert property (@(posedge bus) !rst_n |-> !sto.valid)
    else begin
      $error("output valid during reset");
      n_fail++;
    end

endmodule : osc_acq_assert

bind osc_acq osc_acq_assert u_acq_assert (
  .bus       (bus),
  .rst_n     (rst_n),
  .sto       (sto),
  .sto_ready (sto_ready),
  .evn_lst   (evn_lst)
);

`default_nettype wire

//--- testbench/osc_tb_clk.sv
////////////////////////////////////////
// testbench clock and reset generator
////////////////////////////////////////

`default_nettype none

module osc_tb_clk (
  output logic bus,
  output logic rst_n
);

  // clock period and reset length
  localparam int period     = 40;
  localparam int rst_cycles = 2;

  initial begin
    bus = 1'b0;
    forever #(period / 2) bus = ~bus;
  end

  // reset low for the first cycles
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge bus);
    rst_n <= 1'b1;
  end

endmodule : osc_tb_clk

`default_nettype wire

//--- source/osc_top.sv
////////////////////////////////////////
// oscilloscope channel top
// registers, decimator, trigger, acquire
////////////////////////////////////////

`default_nettype none

module osc_top
  import osc_stream_pkg::*;
  import osc_bus_pkg::*;
(
  input  logic       bus,
  input  logic       rst_n,
  input  bus_req_t   bus_req,
  output bus_rsp_t   bus_rsp,
  input  logic [1:0] ext_evn,
  input  stream_t    adc_in,
  output logic       adc_ready,
  output stream_t    scope_out,
  input  logic       scope_ready,
  output logic       evn_lst
);

  // control and configuration
  logic      ctl_rst;
  logic      sw_str;
  logic      sw_stp;
  logic      sw_trg;
  logic      ctl_str;
  logic      ctl_stp;
  logic      ctl_trg;
  dec_cfg_t  dec_cfg;
  edge_cfg_t edge_cfg;
  acq_cfg_t  acq_cfg;
  acq_sts_t  acq_sts;

  // inner streams
  stream_t dec_out;
  logic    dec_ready;
  stream_t edge_out;
  logic    edge_ready;

  // event sources
  logic                 lvl;
  logic [evn_width-1:0] evn;

  assign evn[evn_sw_str] = sw_str;
  assign evn[evn_sw_stp] = sw_stp;
  assign evn[evn_sw_trg] = sw_trg;
  assign evn[evn_lvl]    = lvl;
  assign evn[evn_ext0]   = ext_evn[0];
  assign evn[evn_ext1]   = ext_evn[1];

  osc_regs u_regs (
    .bus      (bus),
    .rst_n    (rst_n),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .evn      (evn),
    .acq_sts  (acq_sts),
    .ctl_rst  (ctl_rst),
    .sw_str   (sw_str),
    .sw_stp   (sw_stp),
    .sw_trg   (sw_trg),
    .ctl_str  (ctl_str),
    .ctl_stp  (ctl_stp),
    .ctl_trg  (ctl_trg),
    .dec_cfg  (dec_cfg),
    .edge_cfg (edge_cfg),
    .acq_cfg  (acq_cfg)
  );

  osc_dec_avg u_dec_avg (
    .bus       (bus),
    .rst_n     (rst_n),
    .ctl_rst   (ctl_rst),
    .cfg       (dec_cfg),
    .sti       (adc_in),
    .sti_ready (adc_ready),
    .sto       (dec_out),
    .sto_ready (dec_ready)
  );

  osc_edge u_edge (
    .bus       (bus),
    .rst_n     (rst_n),
    .ctl_rst   (ctl_rst),
    .cfg       (edge_cfg),
    .sti       (dec_out),
    .sti_ready (dec_ready),
    .sto       (edge_out),
    .sto_ready (edge_ready),
    .evn_lvl   (lvl)
  );

  osc_acq u_acq (
    .bus       (bus),
    .rst_n     (rst_n),
    .ctl_rst   (ctl_rst),
    .ctl_str   (ctl_str),
    .ctl_stp   (ctl_stp),
    .ctl_trg   (ctl_trg),
    .cfg       (acq_cfg),
    .sts       (acq_sts),
    .sti       (edge_out),
    .sti_ready (edge_ready),
    .sto       (scope_out),
    .sto_ready (scope_ready),
    .evn_lst   (evn_lst)
  );

endmodule : osc_top

`default_nettype wire

//--- source/osc_acq.sv
////////////////////////////////////////
// acquisition controller
// start, trigger, stop, pre/post counts
////////////////////////////////////////

`default_nettype none

module osc_acq
  import osc_stream_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     ctl_rst,
  input  logic     ctl_str,
  input  logic     ctl_stp,
  input  logic     ctl_trg,
  input  acq_cfg_t cfg,
  output acq_sts_t sts,
  input  stream_t  sti,
  output logic     sti_ready,
  output stream_t  sto,
  input  logic     sto_ready,
  output logic     evn_lst
);

  // running, stopped, triggered
  logic                 run;
  logic                 stopped;
  logic                 trig;
  // stop waiting for a stalled beat
  logic                 stp_pnd;
  logic [cnt_width-1:0] pre_cnt;
  logic [cnt_width-1:0] pst_cnt;
  logic [cnt_width-1:0] pst_nxt;

  logic fwd;
  logic trg_acc;
  logic lst;
  logic stall;
  logic end_req;

  ////////////////////////////////////////
  // stream pass-through
  ////////////////////////////////////////

  // idle: keep ready high and drop samples
  assign sti_ready = run ? sto_ready : 1'b1;
  assign fwd       = run & sti.valid & sto_ready;
  assign stall     = run & sti.valid & ~sto_ready;

  assign pst_nxt = pst_cnt + 1'b1;
  assign lst     = fwd & trig & (pst_nxt >= cfg.pst);
  assign trg_acc = ctl_trg & run & ~trig & (pre_cnt >= cfg.pre);
  assign end_req = ctl_stp | stp_pnd;

  assign sto     = '{valid: run & sti.valid, last: lst, data: sti.data};
  assign evn_lst = lst;

  ////////////////////////////////////////
  // state and counters
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      run     <= 1'b0;
      stopped <= 1'b0;
      trig    <= 1'b0;
      stp_pnd <= 1'b0;
      pre_cnt <= '0;
      pst_cnt <= '0;
    end else if (ctl_rst) begin
      run     <= 1'b0;
      stopped <= 1'b0;
      trig    <= 1'b0;
      stp_pnd <= 1'b0;
      pre_cnt <= '0;
      pst_cnt <= '0;
    end else if (ctl_str) begin
      // (re)start clears the record
      run     <= 1'b1;
      stopped <= 1'b0;
      trig    <= 1'b0;
      stp_pnd <= 1'b0;
      pre_cnt <= '0;
      pst_cnt <= '0;
    end else if (run) begin
      if (trg_acc) begin
        trig <= 1'b1;
      end
      // trigger beat still counts as pre
      if (fwd && !trig) begin
        pre_cnt <= pre_cnt + 1'b1;
      end
      if (fwd && trig) begin
        pst_cnt <= pst_nxt;
      end
      if (lst) begin
        run     <= 1'b0;
        stp_pnd <= 1'b0;
      end else if (end_req && stall) begin
        // a presented beat is held until it transfers
        stp_pnd <= 1'b1;
      end else if (end_req) begin
        run     <= 1'b0;
        stopped <= 1'b1;
        stp_pnd <= 1'b0;
      end
    end
  end

  assign sts = '{str: run, stp: stopped, trg: trig, pre_cnt: pre_cnt, pst_cnt: pst_cnt};

endmodule : osc_acq

`default_nettype wire

//--- source/osc_edge.sv
////////////////////////////////////////
// level crossing trigger with hysteresis
// single register stream stage
////////////////////////////////////////

`default_nettype none

module osc_edge
  import osc_stream_pkg::*;
(
  input  logic      bus,
  input  logic      rst_n,
  input  logic      ctl_rst,
  input  edge_cfg_t cfg,
  input  stream_t   sti,
  output logic      sti_ready,
  output stream_t   sto,
  input  logic      sto_ready,
  output logic      evn_lvl
);

  logic    armed;
  logic    out_valid;
  logic    out_last;
  logic    out_trg;
  sample_t out_data;

  sample_t smp;
  sample_t lvl_pos;
  sample_t lvl_neg;
  logic    take;
  logic    arm_hit;
  logic    fire_hit;
  logic    fire;

  assign smp     = sti.data;
  assign lvl_pos = cfg.pos;
  assign lvl_neg = cfg.neg;

  assign sti_ready = ~out_valid | sto_ready;
  assign take      = sti.valid & sti_ready;

  // rising arms low and fires high, falling is the mirror
  assign arm_hit  = cfg.edg ? (smp > lvl_pos) : (smp <= lvl_neg);
  assign fire_hit = cfg.edg ? (smp <= lvl_neg) : (smp >= lvl_pos);
  assign fire     = armed & fire_hit;

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      armed     <= 1'b0;
      out_valid <= 1'b0;
      out_trg   <= 1'b0;
    end else if (ctl_rst) begin
      armed     <= 1'b0;
      out_valid <= 1'b0;
      out_trg   <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
      // crossing flag travels with its sample
      out_trg   <= fire;
      if (fire) begin
        armed <= 1'b0;
      end else if (arm_hit) begin
        armed <= 1'b1;
      end
    end else if (sto_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (take) begin
      out_data <= smp;
      out_last <= sti.last;
    end
  end

  assign sto = '{valid: out_valid, last: out_last, data: out_data};

  // pulse when the crossing sample transfers
  assign evn_lvl = out_valid & out_trg & sto_ready;

endmodule : osc_edge

`default_nettype wire

//--- source/osc_dec_avg.sv
////////////////////////////////////////
// decimator with optional averaging
////////////////////////////////////////

`default_nettype none

module osc_dec_avg
  import osc_stream_pkg::*;
(
  input  logic     bus,
  input  logic     rst_n,
  input  logic     ctl_rst,
  input  dec_cfg_t cfg,
  input  stream_t  sti,
  output logic     sti_ready,
  output stream_t  sto,
  input  logic     sto_ready
);

  // group position and running sum
  logic        [dec_width-1:0]              cnt;
  logic signed [sample_width+dec_width-1:0] acc;
  logic signed [sample_width+dec_width-1:0] sum;
  logic signed [sample_width+dec_width-1:0] avg_shr;

  logic    out_valid;
  logic    out_last;
  sample_t out_data;
  sample_t smp;
  logic    take;
  logic    grp_end;

  assign smp = sti.data;

  // output register frees up on transfer
  assign sti_ready = ~out_valid | sto_ready;
  assign take      = sti.valid & sti_ready;
  assign grp_end   = (cnt == cfg.dec);

  // sum including the current sample
  assign sum     = acc + {{dec_width{smp[sample_width-1]}}, smp};
  assign avg_shr = sum >>> cfg.shr;

  ////////////////////////////////////////
  // group counter and accumulator
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      acc       <= '0;
      out_valid <= 1'b0;
    end else if (ctl_rst) begin
      cnt       <= '0;
      acc       <= '0;
      out_valid <= 1'b0;
    end else begin
      if (take) begin
        if (grp_end) begin
          // restart group
          cnt <= '0;
          acc <= '0;
        end else begin
          cnt <= cnt + 1'b1;
          acc <= sum;
        end
      end
      // new beat on group end, else drop on transfer
      if (take && grp_end) begin
        out_valid <= 1'b1;
      end else if (sto_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // output sample, truncated average or last input
  always_ff @(posedge bus) begin
    if (take && grp_end) begin
      out_data <= cfg.avg ? avg_shr[sample_width-1:0] : smp;
      out_last <= sti.last;
    end
  end

  assign sto = '{valid: out_valid, last: out_last, data: out_data};

endmodule : osc_dec_avg

`default_nettype wire

//--- source/osc_regs.sv
////////////////////////////////////////
// register set on the system bus
// software event pulses, event masks
////////////////////////////////////////

`default_nettype none

module osc_regs
  import osc_stream_pkg::*;
  import osc_bus_pkg::*;
(
  input  logic                 bus,
  input  logic                 rst_n,
  input  bus_req_t             bus_req,
  output bus_rsp_t             bus_rsp,
  input  logic [evn_width-1:0] evn,
  input  acq_sts_t             acq_sts,
  output logic                 ctl_rst,
  output logic                 sw_str,
  output logic                 sw_stp,
  output logic                 sw_trg,
  output logic                 ctl_str,
  output logic                 ctl_stp,
  output logic                 ctl_trg,
  output dec_cfg_t             dec_cfg,
  output edge_cfg_t            edge_cfg,
  output acq_cfg_t             acq_cfg
);

  // event select masks
  logic [evn_width-1:0] msk_str;
  logic [evn_width-1:0] msk_stp;
  logic [evn_width-1:0] msk_trg;

  logic        rsp_ack;
  logic [31:0] rsp_rdata;

  // command decode and status encode share one layout
  ctl_word_u cmd;
  ctl_word_u sts_word;
  logic      wr_ctl;

  assign cmd.raw = bus_req.wdata;
  assign wr_ctl  = bus_req.wen & (bus_req.addr == reg_ctl);

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rsp_ack <= 1'b0;
    end else begin
      rsp_ack <= bus_req.wen | bus_req.ren;
    end
  end

  assign bus_rsp = '{ack: rsp_ack, rdata: rsp_rdata};

  ////////////////////////////////////////
  // write access
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      msk_str  <= '0;
      msk_stp  <= '0;
      msk_trg  <= '0;
      acq_cfg  <= '0;
      edge_cfg <= '0;
      dec_cfg  <= '0;
    end else if (bus_req.wen) begin
      case (bus_req.addr)
        // event masks
        reg_msk_str: msk_str <= bus_req.wdata[evn_width-1:0];
        reg_msk_stp: msk_stp <= bus_req.wdata[evn_width-1:0];
        reg_msk_trg: msk_trg <= bus_req.wdata[evn_width-1:0];
        // pre/post trigger length
        reg_pre: acq_cfg.pre <= bus_req.wdata[cnt_width-1:0];
        reg_pst: acq_cfg.pst <= bus_req.wdata[cnt_width-1:0];
        // trigger levels and edge
        reg_pos: edge_cfg.pos <= bus_req.wdata[sample_width-1:0];
        reg_neg: edge_cfg.neg <= bus_req.wdata[sample_width-1:0];
        reg_edg: edge_cfg.edg <= bus_req.wdata[0];
        // decimation
        reg_dec: dec_cfg.dec <= bus_req.wdata[dec_width-1:0];
        reg_shr: dec_cfg.shr <= bus_req.wdata[shr_width-1:0];
        reg_avg: dec_cfg.avg <= bus_req.wdata[0];
        default: ;
      endcase
    end
  end

  // command pulses, one cycle after the write
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ctl_rst <= 1'b0;
      sw_str  <= 1'b0;
      sw_stp  <= 1'b0;
      sw_trg  <= 1'b0;
    end else begin
      ctl_rst <= wr_ctl & cmd.fields.rst;
      sw_str  <= wr_ctl & cmd.fields.str;
      sw_stp  <= wr_ctl & cmd.fields.stp;
      sw_trg  <= wr_ctl & cmd.fields.trg;
    end
  end

  ////////////////////////////////////////
  // read access
  ////////////////////////////////////////

  // flags at the command bit positions, rst reads 0
  always_comb begin
    sts_word.raw        = '0;
    sts_word.fields.str = acq_sts.str;
    sts_word.fields.stp = acq_sts.stp;
    sts_word.fields.trg = acq_sts.trg;
  end

  always_ff @(posedge bus) begin
    if (bus_req.ren) begin
      case (bus_req.addr)
        reg_ctl:     rsp_rdata <= sts_word.raw;
        reg_msk_str: rsp_rdata <= 32'(msk_str);
        reg_msk_stp: rsp_rdata <= 32'(msk_stp);
        reg_msk_trg: rsp_rdata <= 32'(msk_trg);
        reg_pre:     rsp_rdata <= 32'(acq_cfg.pre);
        reg_pst:     rsp_rdata <= 32'(acq_cfg.pst);
        // live counters
        reg_sts_pre: rsp_rdata <= 32'(acq_sts.pre_cnt);
        reg_sts_pst: rsp_rdata <= 32'(acq_sts.pst_cnt);
        // levels are sign extended
        reg_pos: rsp_rdata <= {{(32-sample_width){edge_cfg.pos[sample_width-1]}}, edge_cfg.pos};
        reg_neg: rsp_rdata <= {{(32-sample_width){edge_cfg.neg[sample_width-1]}}, edge_cfg.neg};
        reg_edg: rsp_rdata <= 32'(edge_cfg.edg);
        reg_dec: rsp_rdata <= 32'(dec_cfg.dec);
        reg_shr: rsp_rdata <= 32'(dec_cfg.shr);
        reg_avg: rsp_rdata <= 32'(dec_cfg.avg);
        default: rsp_rdata <= '0;
      endcase
    end
  end

  ////////////////////////////////////////
  // event selection
  ////////////////////////////////////////

  // any selected event fires the strobe
  assign ctl_str = |(evn & msk_str);
  assign ctl_stp = |(evn & msk_stp);
  assign ctl_trg = |(evn & msk_trg);

endmodule : osc_regs

`default_nettype wire

//--- source/osc_bus_pkg.sv
////////////////////////////////////////
// system bus request/response structs
// register map and control word union
// event vector layout
////////////////////////////////////////

`default_nettype none

package osc_bus_pkg;

  localparam int unsigned addr_width = 7;

  ////////////////////////////////////////
  // bus
  ////////////////////////////////////////

  // wen/ren are single cycle strobes
  typedef struct packed {
    logic                  wen;
    logic                  ren;
    logic [addr_width-1:0] addr;
    logic [31:0]           wdata;
  } bus_req_t;

  // ack one cycle after the request
  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

  ////////////////////////////////////////
  // register offsets
  ////////////////////////////////////////

  localparam logic [addr_width-1:0] reg_ctl     = 'h00;
  localparam logic [addr_width-1:0] reg_msk_str = 'h04;
  localparam logic [addr_width-1:0] reg_msk_stp = 'h08;
  localparam logic [addr_width-1:0] reg_msk_trg = 'h0c;
  localparam logic [addr_width-1:0] reg_pre     = 'h10;
  localparam logic [addr_width-1:0] reg_pst     = 'h14;
  localparam logic [addr_width-1:0] reg_sts_pre = 'h18;
  localparam logic [addr_width-1:0] reg_sts_pst = 'h1c;
  localparam logic [addr_width-1:0] reg_pos     = 'h20;
  localparam logic [addr_width-1:0] reg_neg     = 'h24;
  localparam logic [addr_width-1:0] reg_edg     = 'h28;
  localparam logic [addr_width-1:0] reg_dec     = 'h30;
  localparam logic [addr_width-1:0] reg_shr     = 'h34;
  localparam logic [addr_width-1:0] reg_avg     = 'h38;

  ////////////////////////////////////////
  // control word
  ////////////////////////////////////////

  // bit 0 is rst, bit 3 is trg
  typedef struct packed {
    logic [27:0] pad;
    logic        trg;
    logic        stp;
    logic        str;
    logic        rst;
  } ctl_fields_t;

  // write: command bits, read: status flags
  typedef union packed {
    logic [31:0] raw;
    ctl_fields_t fields;
  } ctl_word_u;

  ////////////////////////////////////////
  // event vector
  ////////////////////////////////////////

  localparam int unsigned evn_width  = 6;
  localparam int unsigned evn_sw_str = 0;
  localparam int unsigned evn_sw_stp = 1;
  localparam int unsigned evn_sw_trg = 2;
  localparam int unsigned evn_lvl    = 3;
  localparam int unsigned evn_ext0   = 4;
  localparam int unsigned evn_ext1   = 5;

endpackage : osc_bus_pkg

`default_nettype wire

//--- source/osc_stream_pkg.sv
////////////////////////////////////////
// sample and stream types
// decimator, trigger and acquisition
// configuration and status structs
////////////////////////////////////////

`default_nettype none

package osc_stream_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // adc sample
  localparam int unsigned sample_width = 16;
  // decimation factor
  localparam int unsigned dec_width = 17;
  // averaging shift
  localparam int unsigned shr_width = 4;
  // pre/post trigger counters
  localparam int unsigned cnt_width = 31;

  ////////////////////////////////////////
  // stream
  ////////////////////////////////////////

  typedef logic signed [sample_width-1:0] sample_t;

  // ready travels separately, against the flow
  typedef struct packed {
    logic    valid;
    logic    last;
    sample_t data;
  } stream_t;

  ////////////////////////////////////////
  // datapath configuration
  ////////////////////////////////////////

  typedef struct packed {
    logic                 avg;
    logic [dec_width-1:0] dec;
    logic [shr_width-1:0] shr;
  } dec_cfg_t;

  // edg: 0 rising, 1 falling
  typedef struct packed {
    sample_t pos;
    sample_t neg;
    logic    edg;
  } edge_cfg_t;

  typedef struct packed {
    logic [cnt_width-1:0] pre;
    logic [cnt_width-1:0] pst;
  } acq_cfg_t;

  // active flags and live counters
  typedef struct packed {
    logic                 str;
    logic                 stp;
    logic                 trg;
    logic [cnt_width-1:0] pre_cnt;
    logic [cnt_width-1:0] pst_cnt;
  } acq_sts_t;

endpackage : osc_stream_pkg

`default_nettype wire
